// File: Makefile
TOOL     := verilator
FLAGS    := --binary --timing --assert -Wno-fatal
TOP      := tb_histo_draw
FILELIST := histo_scope.f
OBJ_DIR  := obj_dir
LOG      := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with $(TOOL) and run $(TOP), log in $(LOG)"
	@echo "  clean  remove build output and log"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || echo "Test FAILED" >> $(LOG)
	@cat $(LOG)
	@if grep -q "Test FAILED" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: histo_scope.f
src/histo_pkg.sv
src/ring_sequencer.sv
src/bar_scaler.sv
src/pixel_writer.sv
src/mem_port_arbiter.sv
src/histo_draw_top.sv
testbench/sdram_model.sv
testbench/tb_histo_draw.sv

// File: src/bar_scaler.sv
`timescale 1ns/1ps
`default_nettype none

module bar_scaler #(
    parameter int LINE_PIXELS = 480,
    parameter int GRAM_BASE   = 9600,
    parameter int X_OFFSET    = 10,
    parameter int MAX_HEIGHT  = 210
) (
    input  wire                clk,
    input  wire                rst_n,
    input  histo_pkg::sample_t line_sample,
    input  histo_pkg::line_t   line_idx,
    input  wire                line_go,
    output histo_pkg::addr_t   bar_start,
    output histo_pkg::height_t bar_height,
    output logic               bar_go
);

    logic [14:0]        half;       // Count halved.
    histo_pkg::height_t height_c;
    histo_pkg::addr_t   line_base;  // Word address of the line start.
    histo_pkg::addr_t   start_c;

    assign half = line_sample[15:1];

    // Clamp keeps the bar inside the plot area.
    assign height_c = (half > 15'(MAX_HEIGHT)) ? histo_pkg::height_t'(MAX_HEIGHT)
                                               : histo_pkg::height_t'(half);

    assign line_base = histo_pkg::addr_t'(GRAM_BASE)
                     + histo_pkg::addr_t'(line_idx) * histo_pkg::addr_t'(LINE_PIXELS);

    // Top pixel, the bar runs down to the base column.
    assign start_c = line_base + histo_pkg::addr_t'(X_OFFSET)
                   + histo_pkg::addr_t'(height_c);

    //////////////////////////////////////////////////
    // One cycle of latency.
    //////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bar_go <= 1'b0;
        end else begin
            bar_go <= line_go;              // Follows line_go by one cycle.
        end
    end

    always_ff @(posedge clk) begin
        if (line_go) begin
            bar_start  <= start_c;
            bar_height <= height_c;
        end
    end

endmodule

`default_nettype wire

// File: src/histo_draw_top.sv
`timescale 1ns/1ps
`default_nettype none

module histo_draw_top #(
    parameter int RING_DEPTH  = 600,
    parameter int LINE_PIXELS = 480,
    parameter int RING_BASE   = 384000,
    parameter int GRAM_BASE   = 9600,
    parameter int X_OFFSET    = 10,
    parameter int MAX_HEIGHT  = 210
) (
    input  wire                clk,
    input  wire                rst_n,
    input  wire                en,
    input  wire                data_update,
    input  histo_pkg::sample_t pulse_count,
    output logic               rd_req,
    output histo_pkg::addr_t   rd_addr,
    input  histo_pkg::pixel_t  rd_data,
    input  wire                rd_done,
    output logic               wr_req,
    output histo_pkg::addr_t   wr_addr,
    output histo_pkg::pixel_t  wr_data,
    input  wire                wr_done,
    output logic               frame_done
);

    histo_pkg::mem_req_t seq_req;
    histo_pkg::mem_req_t pix_req;
    logic                seq_valid;
    logic                seq_done;
    histo_pkg::sample_t  seq_rdata;
    logic                pix_valid;
    logic                pix_done;
    histo_pkg::sample_t  line_sample;
    histo_pkg::line_t    line_idx;
    logic                line_go;
    histo_pkg::addr_t    bar_start;
    histo_pkg::height_t  bar_height;
    logic                bar_go;
    logic                bar_done;

    //////////////////////////////////////////////////
    // Decode, ring slot per line.
    //////////////////////////////////////////////////
    ring_sequencer #(
        .RING_DEPTH (RING_DEPTH),
        .RING_BASE  (RING_BASE)
    ) u_decode (
        .clk, .rst_n, .en, .data_update, .pulse_count,
        .seq_done, .seq_req, .seq_valid, .seq_rdata,
        .line_sample, .line_idx, .line_go, .bar_done, .frame_done
    );

    // Execute, count to bar.
    bar_scaler #(
        .LINE_PIXELS (LINE_PIXELS),
        .GRAM_BASE   (GRAM_BASE),
        .X_OFFSET    (X_OFFSET),
        .MAX_HEIGHT  (MAX_HEIGHT)
    ) u_execute (
        .clk, .rst_n, .line_sample, .line_idx, .line_go,
        .bar_start, .bar_height, .bar_go
    );

    // Result, pixel writes.
    pixel_writer u_result (
        .clk, .rst_n, .en, .bar_start, .bar_height, .bar_go,
        .pix_req, .pix_valid, .pix_done, .bar_done
    );

    mem_port_arbiter u_arb (
        .clk, .rst_n, .seq_req, .seq_valid, .pix_req, .pix_valid,
        .seq_done, .seq_rdata, .pix_done,
        .rd_req, .rd_addr, .rd_data, .rd_done,
        .wr_req, .wr_addr, .wr_data, .wr_done
    );

endmodule

`default_nettype wire

// File: src/histo_pkg.sv
`default_nettype none

package histo_pkg;

    //////////////////////////////////////////////////
    // Widths that carry a meaning.
    //////////////////////////////////////////////////
    typedef logic [23:0] addr_t;    // Bank + row + column word address.
    typedef logic [15:0] pixel_t;   // RGB565, also the memory data width.
    typedef logic [15:0] sample_t;  // One pulse count.
    typedef logic [9:0]  height_t;  // Bar height in pixels.
    typedef logic [9:0]  line_t;    // Display line or ring slot.

    // One memory access as it travels to the port.
    typedef struct packed {
        addr_t  addr;
        pixel_t data;
        logic   we;     // 1 write, 0 read.
    } mem_req_t;

    //////////////////////////////////////////////////
    // State machines.
    //////////////////////////////////////////////////
    typedef enum logic [2:0] {
        SEQ_IDLE,       // Waiting for a new count.
        SEQ_CLEAR,      // Zeroing the ring after reset.
        SEQ_PUT_NEW,    // Ring write of the new count.
        SEQ_GET_LINE,   // Ring read for one line.
        SEQ_WAIT_BAR,   // Bar being drawn.
        SEQ_FRAME_END
    } seq_state_t;

    typedef enum logic [1:0] {
        WR_IDLE,
        WR_WRITE,       // Pixel write outstanding.
        WR_STEP         // Move one pixel down.
    } wr_state_t;

    // Pink.
    localparam pixel_t BAR_COLOR = 16'hFE19;

endpackage

`default_nettype wire

// File: src/mem_port_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module mem_port_arbiter (
    input  wire                 clk,
    input  wire                 rst_n,
    input  histo_pkg::mem_req_t seq_req,
    input  wire                 seq_valid,
    input  histo_pkg::mem_req_t pix_req,
    input  wire                 pix_valid,
    output logic                seq_done,
    output histo_pkg::sample_t  seq_rdata,
    output logic                pix_done,
    // SDRAM glue, read side.
    output logic                rd_req,
    output histo_pkg::addr_t    rd_addr,
    input  histo_pkg::pixel_t   rd_data,
    input  wire                 rd_done,
    // SDRAM glue, write side.
    output logic                wr_req,
    output histo_pkg::addr_t    wr_addr,
    output histo_pkg::pixel_t   wr_data,
    input  wire                 wr_done
);

    logic                busy;      // Request outstanding.
    logic                own_pix;   // Owner, 0 sequencer, 1 writer.
    logic                done_c;
    histo_pkg::mem_req_t grant_c;

    // Done of whichever side is raised.
    assign done_c = (rd_req && rd_done) || (wr_req && wr_done);

    assign seq_done  = done_c && !own_pix;
    assign pix_done  = done_c && own_pix;
    assign seq_rdata = rd_data;     // Valid in the done cycle.

    // Sequencer wins a tie.
    assign grant_c = seq_valid ? seq_req : pix_req;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy    <= 1'b0;
            own_pix <= 1'b0;
            rd_req  <= 1'b0;
            wr_req  <= 1'b0;
            rd_addr <= '0;
            wr_addr <= '0;
            wr_data <= '0;
        end else if (!busy) begin
            if (seq_valid || pix_valid) begin
                busy    <= 1'b1;
                own_pix <= !seq_valid;
                if (grant_c.we) begin
                    wr_req  <= 1'b1;
                    wr_addr <= grant_c.addr;
                    wr_data <= grant_c.data;
                end else begin
                    rd_req  <= 1'b1;
                    rd_addr <= grant_c.addr;
                end
            end
        end else if (done_c) begin
            busy   <= 1'b0;     // Owner drops valid in this same edge.
            rd_req <= 1'b0;
            wr_req <= 1'b0;
        end
    end

    //////////////////////////////////////////////////
    // Checks.
    //////////////////////////////////////////////////
    // One side at a time, and the owner keeps asking until done.
    a_one_side: assert property (@(posedge clk) disable iff (!rst_n)
        (rd_req || wr_req) |-> !(rd_req && wr_req) && (own_pix ? pix_valid : seq_valid));

endmodule

`default_nettype wire

// File: src/pixel_writer.sv
`timescale 1ns/1ps
`default_nettype none

module pixel_writer (
    input  wire                 clk,
    input  wire                 rst_n,
    input  wire                 en,
    input  histo_pkg::addr_t    bar_start,
    input  histo_pkg::height_t  bar_height,
    input  wire                 bar_go,
    output histo_pkg::mem_req_t pix_req,
    output logic                pix_valid,
    input  wire                 pix_done,
    output logic                bar_done
);

    histo_pkg::wr_state_t state;
    histo_pkg::addr_t     addr;     // Current pixel.
    histo_pkg::height_t   left;     // Pixels still below the current one.
    logic                 go_q;     // Bar waiting to start.
    logic                 ack;      // Write done seen.

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= histo_pkg::WR_IDLE;
            addr      <= '0;
            left      <= '0;
            go_q      <= 1'b0;
            ack       <= 1'b0;
            pix_req   <= '0;
            pix_valid <= 1'b0;
            bar_done  <= 1'b0;
        end else begin
            bar_done <= 1'b0;

            // Start and done are caught even while paused.
            if (bar_go) begin
                go_q <= 1'b1;
                addr <= bar_start;
                left <= bar_height;
            end
            if (pix_done) begin
                pix_valid <= 1'b0;
                ack       <= 1'b1;
            end

            if (en) begin
                case (state)
                    histo_pkg::WR_IDLE: begin
                        if (go_q) begin
                            go_q      <= 1'b0;
                            pix_req   <= '{addr: addr, data: histo_pkg::BAR_COLOR, we: 1'b1};
                            pix_valid <= 1'b1;      // Top pixel first.
                            state     <= histo_pkg::WR_WRITE;
                        end
                    end
                    histo_pkg::WR_WRITE: begin
                        if (ack) begin
                            ack   <= 1'b0;
                            state <= histo_pkg::WR_STEP;
                        end
                    end
                    histo_pkg::WR_STEP: begin
                        if (left == '0) begin
                            bar_done <= 1'b1;       // Base column written.
                            state    <= histo_pkg::WR_IDLE;
                        end else begin
                            addr      <= addr - 1'b1;
                            left      <= left - 1'b1;
                            pix_req   <= '{addr: addr - 1'b1,
                                           data: histo_pkg::BAR_COLOR,
                                           we:   1'b1};
                            pix_valid <= 1'b1;
                            state     <= histo_pkg::WR_WRITE;
                        end
                    end
                    default: state <= histo_pkg::WR_IDLE;
                endcase
            end
        end
    end

    //////////////////////////////////////////////////
    // Checks.
    //////////////////////////////////////////////////
    // Sequencer waits for bar_done before the next line.
    a_go_idle: assert property (@(posedge clk) disable iff (!rst_n)
        bar_go |-> (state == histo_pkg::WR_IDLE) && !go_q && !pix_valid);

endmodule

`default_nettype wire

// File: src/ring_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module ring_sequencer #(
    parameter int RING_DEPTH = 600,
    parameter int RING_BASE  = 384000
) (
    input  wire                 clk,
    input  wire                 rst_n,
    input  wire                 en,
    input  wire                 data_update,
    input  histo_pkg::sample_t  pulse_count,
    input  wire                 seq_done,
    output histo_pkg::mem_req_t seq_req,
    output logic                seq_valid,
    input  histo_pkg::sample_t  seq_rdata,
    output histo_pkg::sample_t  line_sample,
    output histo_pkg::line_t    line_idx,
    output logic                line_go,
    input  wire                 bar_done,
    output logic                frame_done
);

    histo_pkg::seq_state_t state;
    histo_pkg::line_t      wp;      // Next ring slot to write, clear pointer too.
    histo_pkg::line_t      rp;      // Ring slot of the current line.
    histo_pkg::line_t      line;    // Current display line.
    histo_pkg::sample_t    cnt_q;   // Latched count.
    histo_pkg::sample_t    rdata_q; // Read data caught at done.
    logic                  pending; // Count not yet drawn.
    logic                  ack;     // Done seen, not yet consumed.
    logic                  bar_ack; // Bar done seen, not yet consumed.

    // Slot index wraps at the ring depth.
    function automatic histo_pkg::line_t next_slot(input histo_pkg::line_t slot);
        return (slot == histo_pkg::line_t'(RING_DEPTH - 1)) ? '0 : slot + 1'b1;
    endfunction

    function automatic histo_pkg::addr_t ring_addr(input histo_pkg::line_t slot);
        return histo_pkg::addr_t'(RING_BASE) + histo_pkg::addr_t'(slot);
    endfunction

    //////////////////////////////////////////////////
    // Frame sequencing.
    //////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= histo_pkg::SEQ_CLEAR; // Clear runs first.
            wp         <= '0;
            rp         <= '0;
            line       <= '0;
            cnt_q      <= '0;
            rdata_q    <= '0;
            pending    <= 1'b0;
            ack        <= 1'b0;
            bar_ack    <= 1'b0;
            seq_req    <= '0;
            seq_valid  <= 1'b0;
            line_sample <= '0;
            line_idx   <= '0;
            line_go    <= 1'b0;
            frame_done <= 1'b0;
        end else begin
            line_go    <= 1'b0;                 // Pulses.
            frame_done <= 1'b0;

            // Done is caught even while paused.
            if (seq_done) begin
                seq_valid <= 1'b0;
                ack       <= 1'b1;
                rdata_q   <= seq_rdata;
            end
            if (bar_done)
                bar_ack <= 1'b1;

            if (en) begin
                case (state)
                    histo_pkg::SEQ_CLEAR: begin
                        if (!seq_valid && !ack) begin
                            seq_req   <= '{addr: ring_addr(wp), data: '0, we: 1'b1};
                            seq_valid <= 1'b1;
                        end else if (ack) begin
                            ack <= 1'b0;
                            wp  <= next_slot(wp);   // Ends back at slot 0.
                            if (wp == histo_pkg::line_t'(RING_DEPTH - 1))
                                state <= histo_pkg::SEQ_IDLE;
                        end
                    end
                    histo_pkg::SEQ_IDLE: begin
                        if (pending) begin
                            pending   <= 1'b0;
                            seq_req   <= '{addr: ring_addr(wp), data: cnt_q, we: 1'b1};
                            seq_valid <= 1'b1;
                            state     <= histo_pkg::SEQ_PUT_NEW;
                        end
                    end
                    histo_pkg::SEQ_PUT_NEW: begin
                        if (ack) begin
                            ack   <= 1'b0;
                            wp    <= next_slot(wp);
                            rp    <= next_slot(wp); // Oldest sample sits after the new one.
                            line  <= '0;
                            state <= histo_pkg::SEQ_GET_LINE;
                        end
                    end
                    histo_pkg::SEQ_GET_LINE: begin
                        if (!seq_valid && !ack) begin
                            seq_req   <= '{addr: ring_addr(rp), data: '0, we: 1'b0};
                            seq_valid <= 1'b1;
                        end else if (ack) begin
                            ack         <= 1'b0;
                            line_sample <= rdata_q;
                            line_idx    <= line;
                            line_go     <= 1'b1;    // Scaler starts.
                            state       <= histo_pkg::SEQ_WAIT_BAR;
                        end
                    end
                    histo_pkg::SEQ_WAIT_BAR: begin
                        if (bar_done || bar_ack) begin
                            bar_ack <= 1'b0;
                            if (line == histo_pkg::line_t'(RING_DEPTH - 1)) begin
                                state <= histo_pkg::SEQ_FRAME_END;
                            end else begin
                                line  <= line + 1'b1;
                                rp    <= next_slot(rp);
                                state <= histo_pkg::SEQ_GET_LINE;
                            end
                        end
                    end
                    histo_pkg::SEQ_FRAME_END: begin
                        frame_done <= 1'b1;
                        state      <= histo_pkg::SEQ_IDLE;
                    end
                    default: state <= histo_pkg::SEQ_IDLE;
                endcase
            end

            // A later update overwrites an unprocessed one.
            if (data_update) begin
                cnt_q   <= pulse_count;
                pending <= 1'b1;
            end
        end
    end

    //////////////////////////////////////////////////
    // Checks.
    //////////////////////////////////////////////////
    a_req_held: assert property (@(posedge clk) disable iff (!rst_n)
        seq_valid && !seq_done |=> seq_valid && $stable(seq_req));

    a_ptr_range: assert property (@(posedge clk) disable iff (!rst_n)
        (32'(wp) < RING_DEPTH) && (32'(rp) < RING_DEPTH));

endmodule

`default_nettype wire

// File: testbench/histo_stimulus.txt
// Columns: idle cycles, count, expected bar height, mode (hex, 16 bits each).
// Mode 0 plain, 1 random en pauses, 2 overwritten by the next line's count.
0003_0000_0000_0000
0000_0001_0000_0000
0005_0064_0014_0000
0002_FFFF_0014_0000
0001_0015_000A_0000
0004_0028_0014_0001
0000_0007_0003_0000
0003_0026_0013_0001
0002_0010_0008_0000
0001_1234_0000_0002
0000_0009_0004_0000
0006_0029_0014_0000
0002_0003_0001_0001

// File: testbench/sdram_model.sv
`timescale 1ns/1ps
`default_nettype none

module sdram_model #(
    parameter int LOG_MAX = 4096
) (
    input  wire                clk,
    input  wire                rst_n,
    input  wire                rd_req,
    input  histo_pkg::addr_t   rd_addr,
    output histo_pkg::pixel_t  rd_data,
    output logic               rd_done,
    input  wire                wr_req,
    input  histo_pkg::addr_t   wr_addr,
    input  histo_pkg::pixel_t  wr_data,
    output logic               wr_done,
    output int                 log_len     // Accesses completed so far.
);

    histo_pkg::pixel_t mem [0:2047];        // Low 11 address bits only.
    histo_pkg::addr_t  log_addr [0:LOG_MAX-1];
    histo_pkg::pixel_t log_data [0:LOG_MAX-1];
    logic              log_we [0:LOG_MAX-1];
    int                seed;
    int                wait_left;           // Cycles until done.
    logic              active;              // Request accepted.

    initial begin
        seed = 3;
        for (int i = 0; i < 2048; i++) begin
            mem[i] = histo_pkg::pixel_t'(i) ^ 16'h5A5A;  // Junk before the clear.
        end
    end

    //////////////////////////////////////////////////
    // One access at a time, random latency.
    //////////////////////////////////////////////////
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_done   <= 1'b0;
            wr_done   <= 1'b0;
            rd_data   <= '0;
            active    <= 1'b0;
            wait_left <= 0;
            log_len   <= 0;
        end else begin
            rd_done <= 1'b0;
            wr_done <= 1'b0;
            if (!active) begin
                // Request still high in the done cycle, skip it.
                if ((rd_req || wr_req) && !rd_done && !wr_done) begin
                    active    <= 1'b1;
                    wait_left <= $unsigned($random(seed)) % 4;
                end
            end else if (wait_left != 0) begin
                wait_left <= wait_left - 1;
            end else begin
                active <= 1'b0;
                if (log_len < LOG_MAX) begin
                    log_addr[log_len] <= wr_req ? wr_addr : rd_addr;
                    log_data[log_len] <= wr_req ? wr_data : mem[rd_addr[10:0]];
                    log_we[log_len]   <= wr_req;
                end
                log_len <= log_len + 1;
                if (wr_req) begin
                    mem[wr_addr[10:0]] <= wr_data;
                    wr_done            <= 1'b1;
                end else begin
                    rd_data <= mem[rd_addr[10:0]];  // Valid with done.
                    rd_done <= 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: testbench/tb_histo_draw.sv
`timescale 1ns/1ps
`default_nettype none

module tb_histo_draw;

    localparam int RING_DEPTH    = 8;
    localparam int LINE_PIXELS   = 32;
    localparam int RING_BASE     = 1024;
    localparam int GRAM_BASE     = 0;
    localparam int X_OFFSET      = 2;
    localparam int MAX_HEIGHT    = 20;
    localparam int STIM_MAX      = 32;
    localparam int CLEAR_TIMEOUT = 2000;    // Cycles.
    localparam int FRAME_TIMEOUT = 20000;
    localparam histo_pkg::pixel_t PINK = 16'hFE19;

    logic               clk;
    logic               rst_n;
    logic               en;
    logic               data_update;
    histo_pkg::sample_t pulse_count;
    logic               rd_req;
    logic               rd_done;
    logic               wr_req;
    logic               wr_done;
    logic               frame_done;
    histo_pkg::addr_t   rd_addr;
    histo_pkg::addr_t   wr_addr;
    histo_pkg::pixel_t  rd_data;
    histo_pkg::pixel_t  wr_data;
    int                 log_len;

    logic [63:0]        stim [0:STIM_MAX-1];    // Idle, count, height, mode.
    histo_pkg::sample_t ring_cnt [0:RING_DEPTH-1];
    histo_pkg::height_t ring_h [0:RING_DEPTH-1];
    int                 wp;                     // Ring slot of the next count.
    int                 pos;                    // Next log entry to check.
    int                 errors;
    int                 timeouts;
    int                 seed;
    logic               stop;
    logic               hold_low;               // Count waits with en low.
    int                 idx;
    int                 idle;
    histo_pkg::sample_t cnt;
    histo_pkg::height_t hgt;
    logic [15:0]        mode;

    always #20 clk = ~clk;

    histo_draw_top #(
        .RING_DEPTH  (RING_DEPTH),
        .LINE_PIXELS (LINE_PIXELS),
        .RING_BASE   (RING_BASE),
        .GRAM_BASE   (GRAM_BASE),
        .X_OFFSET    (X_OFFSET),
        .MAX_HEIGHT  (MAX_HEIGHT)
    ) DUT (
        .clk, .rst_n, .en, .data_update, .pulse_count,
        .rd_req, .rd_addr, .rd_data, .rd_done,
        .wr_req, .wr_addr, .wr_data, .wr_done, .frame_done
    );

    sdram_model ram (
        .clk, .rst_n, .rd_req, .rd_addr, .rd_data, .rd_done,
        .wr_req, .wr_addr, .wr_data, .wr_done, .log_len
    );

    //////////////////////////////////////////////////
    // Compare tasks.
    //////////////////////////////////////////////////
    task automatic check_addr(input histo_pkg::addr_t got, input histo_pkg::addr_t exp,
                              input string what);
        if (got !== exp) begin
            errors++;
            $display("FAIL at %t: %s address %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_pixel(input histo_pkg::pixel_t got, input histo_pkg::pixel_t exp,
                               input string what);
        if (got !== exp) begin
            errors++;
            $display("FAIL at %t: %s pixel %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_sample(input histo_pkg::sample_t got, input histo_pkg::sample_t exp,
                                input string what);
        if (got !== exp) begin
            errors++;
            $display("FAIL at %t: %s sample %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    // Log entry at pos must exist and be of the right kind.
    task automatic next_access(input logic exp_we, input string what, output logic ok);
        ok = 1'b0;
        if (pos >= log_len) begin
            errors++;
            $display("FAIL at %t: %s missing, log ends at entry %0d", $time, what, pos);
        end else if (ram.log_we[pos] !== exp_we) begin
            errors++;
            $display("FAIL at %t: entry %0d has we %b, expected %s", $time, pos,
                     ram.log_we[pos], what);
            pos = log_len;                      // Resync to the log end.
        end else begin
            ok = 1'b1;
        end
    endtask

    task automatic check_quiet;
        if (log_len != pos) begin
            errors++;
            $display("FAIL at %t: %0d memory accesses outside a frame", $time, log_len - pos);
            pos = log_len;
        end
    endtask

    //////////////////////////////////////////////////
    // Reference model of ring and bars.
    //////////////////////////////////////////////////
    task automatic check_clear;
        logic ok;
        for (int i = 0; i < RING_DEPTH; i++) begin
            next_access(1'b1, "ring clear", ok);
            if (!ok) return;
            check_addr(ram.log_addr[pos], histo_pkg::addr_t'(RING_BASE + i), "ring clear");
            check_sample(ram.log_data[pos], '0, "ring clear");
            pos++;
        end
    endtask

    task automatic check_frame(input histo_pkg::sample_t c, input histo_pkg::height_t h);
        int   slot;
        logic ok;
        next_access(1'b1, "ring write", ok);
        if (!ok) return;
        check_addr(ram.log_addr[pos], histo_pkg::addr_t'(RING_BASE + wp), "ring write");
        check_sample(ram.log_data[pos], c, "ring write");
        pos++;
        ring_cnt[wp] = c;
        ring_h[wp]   = h;
        wp = (wp + 1) % RING_DEPTH;             // Oldest slot now at wp.
        for (int y = 0; y < RING_DEPTH; y++) begin
            slot = (wp + y) % RING_DEPTH;
            next_access(1'b0, "ring read", ok);
            if (!ok) return;
            check_addr(ram.log_addr[pos], histo_pkg::addr_t'(RING_BASE + slot), "ring read");
            check_sample(ram.log_data[pos], ring_cnt[slot], "ring read");
            pos++;
            for (int k = int'(ring_h[slot]); k >= 0; k--) begin   // Top pixel first.
                next_access(1'b1, "bar pixel", ok);
                if (!ok) return;
                check_addr(ram.log_addr[pos],
                           histo_pkg::addr_t'(GRAM_BASE + y * LINE_PIXELS + X_OFFSET + k),
                           "bar pixel");
                check_pixel(ram.log_data[pos], PINK, "bar pixel");
                pos++;
            end
        end
        check_quiet();                          // Nothing beyond the frame.
    endtask

    //////////////////////////////////////////////////
    // Stimulus and waits.
    //////////////////////////////////////////////////
    task automatic send_count(input histo_pkg::sample_t c, input logic raise_en);
        @(posedge clk);
        data_update <= 1'b1;
        pulse_count <= c;
        @(posedge clk);
        data_update <= 1'b0;
        if (raise_en)
            en <= 1'b1;
    endtask

    task automatic wait_clear;
        int n;
        for (n = 0; n < CLEAR_TIMEOUT; n++) begin
            @(negedge clk);
            if (log_len >= RING_DEPTH)
                break;
        end
        if (n == CLEAR_TIMEOUT) begin
            $display("Timeout: ring clear did not finish in %0d cycles", CLEAR_TIMEOUT);
            timeouts++;
            stop = 1'b1;
        end
    endtask

    // Pause toggles en in random stretches of 1 to 8 cycles.
    task automatic wait_frame(input logic pause);
        int n;
        int stretch;
        int low_start;
        stretch   = 0;
        low_start = log_len;
        for (n = 0; n < FRAME_TIMEOUT; n++) begin
            @(posedge clk);
            if (pause) begin
                if (stretch == 0) begin
                    stretch = 1 + ($unsigned($random(seed)) % 8);
                    if (en)
                        low_start = log_len;
                    en <= !en;
                end else begin
                    stretch--;
                end
            end
            @(negedge clk);
            // Only the access in flight may finish while paused.
            if (pause && !en && log_len > low_start + 1) begin
                errors++;
                $display("FAIL at %t: %0d accesses while en low", $time, log_len - low_start);
                low_start = log_len;
            end
            if (frame_done)
                break;
        end
        if (n == FRAME_TIMEOUT) begin
            $display("Timeout: no frame_done within %0d cycles", FRAME_TIMEOUT);
            timeouts++;
            stop = 1'b1;
        end
        if (pause) begin
            @(posedge clk);
            en <= 1'b1;
        end
    endtask

    //////////////////////////////////////////////////
    // Main sequence.
    //////////////////////////////////////////////////
    initial begin
        $timeformat(-9, 0, " ns", 0);
        clk         = 1'b0;
        rst_n       = 1'b0;
        en          = 1'b1;
        data_update = 1'b0;
        pulse_count = '0;
        errors      = 0;
        timeouts    = 0;
        seed        = 3;
        stop        = 1'b0;
        hold_low    = 1'b0;
        wp          = 0;
        pos         = 0;
        for (int i = 0; i < RING_DEPTH; i++) begin
            ring_cnt[i] = '0;                   // Cleared ring.
            ring_h[i]   = '0;
        end
        for (int i = 0; i < STIM_MAX; i++)
            stim[i] = '1;                       // Mode FFFF ends the list.
        $readmemh("testbench/histo_stimulus.txt", stim);

        repeat (10) @(posedge clk);
        rst_n <= 1'b1;

        wait_clear();
        if (!stop)
            check_clear();

        for (idx = 0; idx < STIM_MAX; idx++) begin
            if (stop || stim[idx][15:0] == 16'hFFFF)
                break;
            idle = int'(stim[idx][63:48]);
            cnt  = stim[idx][47:32];
            hgt  = histo_pkg::height_t'(stim[idx][31:16]);
            mode = stim[idx][15:0];
            repeat (idle) @(posedge clk);
            @(negedge clk);
            check_quiet();
            if (mode == 16'd2) begin
                @(posedge clk);
                en <= 1'b0;                     // Overwritten by the next count.
                send_count(cnt, 1'b0);
                hold_low = 1'b1;
            end else begin
                send_count(cnt, hold_low);
                hold_low = 1'b0;
                wait_frame(mode == 16'd1);
                if (!stop)
                    check_frame(cnt, hgt);
            end
        end

        if (!stop) begin
            repeat (40) @(posedge clk);
            @(negedge clk);
            check_quiet();                      // No leftover frame.
        end

        $display("Errors: %0d mismatches, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
